//--- compile.f
verilog/alu_pkg.sv
verilog/alu_pipe_reg.sv
verilog/alu_decode_stage.sv
verilog/alu_shifter.sv
verilog/alu_comparator.sv
verilog/alu_execute_stage.sv
verilog/alu_result_stage.sv
verilog/alu_top.sv
testbench/tb_alu_top.sv

//--- testbench/tb_alu_top.sv
// Testbench for the pipelined ALU with directed and random operations under stalls.
// A reference model feeds a queue of expected results checked at the output.
`timescale 1ns/1ps
`default_nettype none

module tb_alu_top import alu_pkg::*; ();

  localparam int NUM_OPS        = 600;
  localparam int NUM_OP_CODES   = 28;
  localparam int RESET_CYCLES   = 16;
  localparam int DRAIN_CYCLES   = 50;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_OPS * 4 + 100;

  typedef struct packed {
    alu_op_e               op;
    logic [DATA_WIDTH-1:0] a;
    logic [DATA_WIDTH-1:0] b;
    logic [DATA_WIDTH-1:0] result;
    logic                  cmp_bit;
    logic [31:0]           cycle;
    logic                  check_latency;
  } expect_t;

  logic                  clk;
  logic                  rst_n_i;
  logic                  valid_i;
  logic                  ready_o;
  alu_op_e               operator_i;
  logic [DATA_WIDTH-1:0] operand_a_i;
  logic [DATA_WIDTH-1:0] operand_b_i;
  logic                  valid_o;
  logic                  ex_ready_i;
  logic [DATA_WIDTH-1:0] result_o;
  logic                  comparison_result_o;

  expect_t               expected_q[$];
  expect_t               entry;
  int                    cycle_count;
  int                    sent_count;
  int                    mismatch_errors;
  int                    other_errors;
  logic [15:0]           lfsr_state;
  logic                  stall_enable;
  // output hold tracking across stalled cycles
  logic                  stall_seen;
  logic [DATA_WIDTH-1:0] held_result;
  logic                  held_bit;

  alu_top i_alu_top (
    .clk                 (clk),
    .rst_n_i             (rst_n_i),
    .valid_i             (valid_i),
    .ready_o             (ready_o),
    .operator_i          (operator_i),
    .operand_a_i         (operand_a_i),
    .operand_b_i         (operand_b_i),
    .valid_o             (valid_o),
    .ex_ready_i          (ex_ready_i),
    .result_o            (result_o),
    .comparison_result_o (comparison_result_o)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////
  // reference model and random source
  ////////////////////////////////////////

  // returns {result word, comparison bit}
  function automatic logic [DATA_WIDTH:0] alu_ref(input alu_op_e op,
                                                  input logic [DATA_WIDTH-1:0] a,
                                                  input logic [DATA_WIDTH-1:0] b);
    logic [DATA_WIDTH-1:0] res;
    logic                  flag;
    logic [4:0]            sh;
    logic                  eq;
    logic                  lt_s;
    logic                  lt_u;
    sh   = b[4:0];
    eq   = (a == b);
    lt_s = ($signed(a) < $signed(b));
    lt_u = (a < b);
    // non-compare operators report a == b
    flag = eq;
    res  = '0;
    case (op)
      ALU_ADD:   res = a + b;
      ALU_SUB:   res = a - b;
      ALU_AND:   res = a & b;
      ALU_OR:    res = a | b;
      ALU_XOR:   res = a ^ b;
      ALU_SLL:   res = a << sh;
      ALU_SRL:   res = a >> sh;
      ALU_SRA:   res = $signed(a) >>> sh;
      ALU_ROR:   res = (a >> sh) | (a << (6'd32 - sh));
      ALU_EQ:    flag = eq;
      ALU_NE:    flag = !eq;
      ALU_GTS:   flag = !lt_s && !eq;
      ALU_GTU:   flag = !lt_u && !eq;
      ALU_GES:   flag = !lt_s;
      ALU_GEU:   flag = !lt_u;
      ALU_LTS,   ALU_SLTS:  flag = lt_s;
      ALU_LTU,   ALU_SLTU:  flag = lt_u;
      ALU_LES,   ALU_SLETS: flag = lt_s || eq;
      ALU_LEU,   ALU_SLETU: flag = lt_u || eq;
      ALU_MIN:   res = lt_s ? a : b;
      ALU_MAX:   res = lt_s ? b : a;
      ALU_MINU:  res = lt_u ? a : b;
      ALU_MAXU:  res = lt_u ? b : a;
      ALU_ABS:
      begin
        res  = a[DATA_WIDTH-1] ? -a : a;
        flag = (a == '0);
      end
      default: ;
    endcase
    // compare words carry a mask and set-less-than only bit 0
    if (op >= ALU_EQ && op <= ALU_LEU)
      res = {DATA_WIDTH{flag}};
    else if (op >= ALU_SLTS && op <= ALU_SLETU)
      res = {{(DATA_WIDTH-1){1'b0}}, flag};
    return {res, flag};
  endfunction

  // 16-bit fibonacci lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  task automatic draw_bits(input int nbits, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < nbits; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = {value[30:0], lfsr_state[0]};
    end
  endtask

  ////////////////////////////////////////
  // drivers
  ////////////////////////////////////////

  // advance to 1 ns past the next rising edge and redraw consumer stalls
  task automatic next_cycle();
    logic [31:0] bits;
    @(posedge clk);
    #1;
    if (stall_enable)
    begin
      draw_bits(2, bits);
      ex_ready_i = (bits[1:0] != 2'b00);
    end
    else
      ex_ready_i = 1'b1;
  endtask

  // present one operation and hold it until ready_o takes it
  task automatic send_op(input alu_op_e op, input logic [DATA_WIDTH-1:0] a,
                         input logic [DATA_WIDTH-1:0] b);
    logic accepted;
    accepted    = 1'b0;
    operator_i  = op;
    operand_a_i = a;
    operand_b_i = b;
    valid_i     = 1'b1;
    while (!accepted)
    begin
      @(negedge clk);
      accepted = ready_o;
      next_cycle();
    end
    valid_i    = 1'b0;
    sent_count = sent_count + 1;
  endtask

  task automatic send_single(input alu_op_e op, input logic [DATA_WIDTH-1:0] a,
                             input logic [DATA_WIDTH-1:0] b);
    send_op(op, a, b);
    next_cycle();
    next_cycle();
  endtask

  // wait until every accepted operation has come out, at most DRAIN_CYCLES
  task automatic drain_pipeline();
    int waited;
    waited = 0;
    while (expected_q.size() != 0 && waited < DRAIN_CYCLES)
    begin
      next_cycle();
      waited = waited + 1;
    end
  endtask

  task automatic run_directed();
    send_single(ALU_ADD,   32'hFFFF_FFFF, 32'h0000_0001);
    send_single(ALU_SUB,   32'h0000_0000, 32'h0000_0001);
    send_single(ALU_AND,   32'hF0F0_A5A5, 32'hFF00_0FF0);
    send_single(ALU_OR,    32'hF0F0_A5A5, 32'hFF00_0FF0);
    send_single(ALU_XOR,   32'hF0F0_A5A5, 32'hF0F0_A5A5);
    send_single(ALU_SLL,   32'h8000_0001, 32'h0000_0000);
    send_single(ALU_SLL,   32'h0000_0003, 32'h0000_001F);
    send_single(ALU_SLL,   32'h1234_5678, 32'h0000_0025);
    send_single(ALU_SRL,   32'h8000_0000, 32'h0000_001F);
    send_single(ALU_SRA,   32'h8000_0000, 32'h0000_001F);
    send_single(ALU_SRA,   32'h8765_4321, 32'h0000_0000);
    send_single(ALU_ROR,   32'h8000_0001, 32'h0000_0001);
    send_single(ALU_ROR,   32'h8000_0001, 32'h0000_001F);
    send_single(ALU_GTS,   32'h7FFF_FFFF, 32'h8000_0000);
    send_single(ALU_GTU,   32'h7FFF_FFFF, 32'h8000_0000);
    send_single(ALU_LES,   32'h8000_0000, 32'h7FFF_FFFF);
    send_single(ALU_GEU,   32'h8000_0000, 32'h8000_0000);
    send_single(ALU_SLTS,  32'h8000_0000, 32'h7FFF_FFFF);
    send_single(ALU_SLETU, 32'h8000_0000, 32'h7FFF_FFFF);
    send_single(ALU_MIN,   32'h8000_0000, 32'h7FFF_FFFF);
    send_single(ALU_MAXU,  32'h8000_0000, 32'h7FFF_FFFF);
    send_single(ALU_ABS,   32'h8000_0000, 32'h0000_0000);
    send_single(ALU_ABS,   32'hFFFF_FFFB, 32'h0000_0000);
    send_single(ALU_ABS,   32'h0000_0000, 32'h0000_0007);
  endtask

  ////////////////////////////////////////
  // timeout
  ////////////////////////////////////////

  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TB FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // scoreboard sampled mid-cycle
  ////////////////////////////////////////

  always @(negedge clk)
  begin
    if (!rst_n_i)
    begin
      stall_seen = 1'b0;
      // the synchronous reset takes hold on the first rising edge
      if (cycle_count > 0)
        assert (valid_o === 1'b0)
        else
        begin
          other_errors = other_errors + 1;
          $display("valid_o was high during reset at %0t", $time);
        end
    end
    else
    begin
      // a stalled output must not move
      if (stall_seen)
        assert (valid_o === 1'b1 && result_o === held_result &&
                comparison_result_o === held_bit)
        else
        begin
          other_errors = other_errors + 1;
          $display("output changed while ex_ready_i was low at %0t", $time);
        end
      stall_seen  = valid_o && !ex_ready_i;
      held_result = result_o;
      held_bit    = comparison_result_o;

      if (valid_o && ex_ready_i)
      begin
        if (expected_q.size() == 0)
        begin
          other_errors = other_errors + 1;
          $display("output at %0t with no operation pending", $time);
        end
        else
        begin
          entry = expected_q.pop_front();
          assert (result_o === entry.result && comparison_result_o === entry.cmp_bit)
          else
          begin
            mismatch_errors = mismatch_errors + 1;
            $display("Mismatch at %0t: %s a=%h b=%h got %h/%b expected %h/%b",
                     $time, entry.op.name(), entry.a, entry.b, result_o,
                     comparison_result_o, entry.result, entry.cmp_bit);
          end
          if (entry.check_latency)
            assert (cycle_count - entry.cycle == 3)
            else
            begin
              other_errors = other_errors + 1;
              $display("latency of %0d cycles instead of 3 at %0t",
                       cycle_count - entry.cycle, $time);
            end
        end
      end

      // input transfer happens on the coming edge
      if (valid_i && ready_o)
      begin
        {entry.result, entry.cmp_bit} = alu_ref(operator_i, operand_a_i, operand_b_i);
        entry.op            = operator_i;
        entry.a             = operand_a_i;
        entry.b             = operand_b_i;
        entry.cycle         = cycle_count;
        entry.check_latency = !stall_enable;
        expected_q.push_back(entry);
      end
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial
  begin : stimulus
    logic [31:0]           bits;
    logic [DATA_WIDTH-1:0] a;
    logic [DATA_WIDTH-1:0] b;
    alu_op_e               op;
    clk             = 1'b0;
    rst_n_i         = 1'b0;
    valid_i         = 1'b0;
    operator_i      = ALU_ADD;
    operand_a_i     = '0;
    operand_b_i     = '0;
    ex_ready_i      = 1'b1;
    lfsr_state      = 16'd73;
    stall_enable    = 1'b0;
    stall_seen      = 1'b0;
    cycle_count     = 0;
    sent_count      = 0;
    mismatch_errors = 0;
    other_errors    = 0;

    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    @(negedge clk);
    assert (ready_o === 1'b1)
    else
    begin
      other_errors = other_errors + 1;
      $display("ready_o was not high after reset");
    end
    next_cycle();

    // directed cases with the consumer always ready
    run_directed();
    drain_pipeline();

    // random traffic with gaps and consumer stalls
    stall_enable = 1'b1;
    while (sent_count < NUM_OPS)
    begin
      draw_bits(2, bits);
      if (bits[1:0] == 2'b00)
        next_cycle();
      else
      begin
        draw_bits(5, bits);
        op = alu_op_e'(bits[4:0] % NUM_OP_CODES);
        draw_bits(32, a);
        draw_bits(2, bits);
        // every fourth pair is equal so eq paths get hit
        if (bits[1:0] == 2'b00)
          b = a;
        else
          draw_bits(32, b);
        send_op(op, a, b);
      end
    end

    stall_enable = 1'b0;
    drain_pipeline();
    // idle tail to catch spurious outputs
    repeat (4) next_cycle();

    if (expected_q.size() != 0)
    begin
      other_errors = other_errors + 1;
      $display("%0d operations never came out", expected_q.size());
    end
    $display("errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
    if (mismatch_errors + other_errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/alu_comparator.sv
// Word comparator built from per-byte equal and greater bits.
// Sign is taken into account on the top byte only.
`timescale 1ns/1ps
`default_nettype none

module alu_comparator import alu_pkg::*; (
  input  logic [DATA_WIDTH-1:0] operand_a_i,
  input  logic [DATA_WIDTH-1:0] operand_b_i,
  input  logic                  signed_i,
  output logic                  is_equal_o,
  output logic                  is_greater_o
);

  logic [NUM_BYTES-1:0] is_equal_vec;
  logic [NUM_BYTES-1:0] is_greater_vec;

  // per-byte compare, extra top bit carries the sign when enabled
  for (genvar i = 0; i < NUM_BYTES; i++)
  begin : g_byte
    logic                  sign_en;
    logic [BYTE_WIDTH-1:0] a_byte;
    logic [BYTE_WIDTH-1:0] b_byte;

    assign sign_en = (i == NUM_BYTES-1) ? signed_i : 1'b0;
    assign a_byte  = operand_a_i[BYTE_WIDTH*i +: BYTE_WIDTH];
    assign b_byte  = operand_b_i[BYTE_WIDTH*i +: BYTE_WIDTH];

    assign is_equal_vec[i]   = (a_byte == b_byte);
    assign is_greater_vec[i] = $signed({a_byte[BYTE_WIDTH-1] & sign_en, a_byte}) >
                               $signed({b_byte[BYTE_WIDTH-1] & sign_en, b_byte});
  end

  // chain from lsb upward, a higher byte decides unless it is equal
  always_comb
  begin
    is_greater_o = 1'b0;
    for (int i = 0; i < NUM_BYTES; i++)
    begin
      is_greater_o = is_greater_vec[i] | (is_equal_vec[i] & is_greater_o);
    end
  end

  assign is_equal_o = &is_equal_vec;

endmodule

`default_nettype wire

//--- verilog/alu_decode_stage.sv
// Operator decode, the only place the opcode is looked at.
// Produces control flags and the prepared adder and compare operands.
`timescale 1ns/1ps
`default_nettype none

module alu_decode_stage import alu_pkg::*; (
  input  alu_op_e               operator_i,
  input  logic [DATA_WIDTH-1:0] operand_a_i,
  input  logic [DATA_WIDTH-1:0] operand_b_i,
  output decode_pld_t           decode_o
);

  always_comb
  begin
    // defaults match a plain add, comparison bit reports a == b
    decode_o.adder_a    = operand_a_i;
    decode_o.adder_b    = operand_b_i;
    decode_o.operand_a  = operand_a_i;
    decode_o.operand_b  = operand_b_i;
    decode_o.carry_in   = 1'b0;
    decode_o.shift_left = 1'b0;
    decode_o.arithmetic = 1'b0;
    decode_o.rotate     = 1'b0;
    decode_o.cmp_signed = 1'b0;
    decode_o.do_min     = 1'b0;
    decode_o.is_abs     = 1'b0;
    decode_o.cmp_mode   = CMP_EQ;
    decode_o.res_sel    = RES_ADD;
    decode_o.logic_op   = LOGIC_AND;

    unique case (operator_i)
      // two's complement subtract
      ALU_SUB:
      begin
        decode_o.adder_b  = ~operand_b_i;
        decode_o.carry_in = 1'b1;
      end

      ALU_AND: decode_o.res_sel = RES_LOGIC;
      ALU_OR:
      begin
        decode_o.res_sel  = RES_LOGIC;
        decode_o.logic_op = LOGIC_OR;
      end
      ALU_XOR:
      begin
        decode_o.res_sel  = RES_LOGIC;
        decode_o.logic_op = LOGIC_XOR;
      end

      // one right shifter serves all four shifts
      ALU_SLL:
      begin
        decode_o.res_sel    = RES_SHIFT;
        decode_o.shift_left = 1'b1;
      end
      ALU_SRL: decode_o.res_sel = RES_SHIFT;
      ALU_SRA:
      begin
        decode_o.res_sel    = RES_SHIFT;
        decode_o.arithmetic = 1'b1;
      end
      ALU_ROR:
      begin
        decode_o.res_sel = RES_SHIFT;
        decode_o.rotate  = 1'b1;
      end

      // comparisons giving a full-word mask
      ALU_EQ: decode_o.res_sel = RES_CMP_WORD;
      ALU_NE:
      begin
        decode_o.res_sel  = RES_CMP_WORD;
        decode_o.cmp_mode = CMP_NE;
      end
      ALU_GTS, ALU_GTU:
      begin
        decode_o.res_sel    = RES_CMP_WORD;
        decode_o.cmp_mode   = CMP_GT;
        decode_o.cmp_signed = (operator_i == ALU_GTS);
      end
      ALU_GES, ALU_GEU:
      begin
        decode_o.res_sel    = RES_CMP_WORD;
        decode_o.cmp_mode   = CMP_GE;
        decode_o.cmp_signed = (operator_i == ALU_GES);
      end
      ALU_LTS, ALU_LTU:
      begin
        decode_o.res_sel    = RES_CMP_WORD;
        decode_o.cmp_mode   = CMP_LT;
        decode_o.cmp_signed = (operator_i == ALU_LTS);
      end
      ALU_LES, ALU_LEU:
      begin
        decode_o.res_sel    = RES_CMP_WORD;
        decode_o.cmp_mode   = CMP_LE;
        decode_o.cmp_signed = (operator_i == ALU_LES);
      end

      // set-less-than family, flag in bit 0 only
      ALU_SLTS, ALU_SLTU:
      begin
        decode_o.res_sel    = RES_CMP_BIT;
        decode_o.cmp_mode   = CMP_LT;
        decode_o.cmp_signed = (operator_i == ALU_SLTS);
      end
      ALU_SLETS, ALU_SLETU:
      begin
        decode_o.res_sel    = RES_CMP_BIT;
        decode_o.cmp_mode   = CMP_LE;
        decode_o.cmp_signed = (operator_i == ALU_SLETS);
      end

      ALU_MIN, ALU_MINU:
      begin
        decode_o.res_sel    = RES_MINMAX;
        decode_o.do_min     = 1'b1;
        decode_o.cmp_signed = (operator_i == ALU_MIN);
      end
      ALU_MAX, ALU_MAXU:
      begin
        decode_o.res_sel    = RES_MINMAX;
        decode_o.cmp_signed = (operator_i == ALU_MAX);
      end

      // abs: adder forms -a, compare a against zero, max picks the result
      ALU_ABS:
      begin
        decode_o.res_sel    = RES_MINMAX;
        decode_o.is_abs     = 1'b1;
        decode_o.cmp_signed = 1'b1;
        decode_o.adder_a    = ~operand_a_i;
        decode_o.adder_b    = '0;
        decode_o.carry_in   = 1'b1;
        decode_o.operand_b  = '0;
      end

      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/alu_execute_stage.sv
// Execute stage, runs adder, bitwise logic, shifter and comparator in parallel.
// Everything the result stage needs goes out in the execute payload.
`timescale 1ns/1ps
`default_nettype none

module alu_execute_stage import alu_pkg::*; (
  input  decode_pld_t decode_i,
  output exec_pld_t   exec_o
);

  logic [DATA_WIDTH-1:0] sum;
  logic [DATA_WIDTH-1:0] logic_result;
  logic [DATA_WIDTH-1:0] shift_result;
  logic                  is_equal;
  logic                  is_greater;

  ////////////////////////////////////////
  // adder
  ////////////////////////////////////////

  // carry-in completes two's complement for sub and abs
  assign sum = decode_i.adder_a + decode_i.adder_b +
               {{(DATA_WIDTH-1){1'b0}}, decode_i.carry_in};

  ////////////////////////////////////////
  // bitwise logic
  ////////////////////////////////////////

  always_comb
  begin
    unique case (decode_i.logic_op)
      LOGIC_OR:  logic_result = decode_i.operand_a | decode_i.operand_b;
      LOGIC_XOR: logic_result = decode_i.operand_a ^ decode_i.operand_b;
      default:   logic_result = decode_i.operand_a & decode_i.operand_b;
    endcase
  end

  ////////////////////////////////////////
  // shift and compare
  ////////////////////////////////////////

  // shift amount is b modulo the word width
  alu_shifter i_alu_shifter (
    .operand_i    (decode_i.operand_a),
    .shamt_i      (decode_i.operand_b[SHAMT_WIDTH-1:0]),
    .shift_left_i (decode_i.shift_left),
    .arithmetic_i (decode_i.arithmetic),
    .rotate_i     (decode_i.rotate),
    .result_o     (shift_result)
  );

  // for abs operand_b is already zero
  alu_comparator i_alu_comparator (
    .operand_a_i  (decode_i.operand_a),
    .operand_b_i  (decode_i.operand_b),
    .signed_i     (decode_i.cmp_signed),
    .is_equal_o   (is_equal),
    .is_greater_o (is_greater)
  );

  ////////////////////////////////////////
  // payload to result stage
  ////////////////////////////////////////

  always_comb
  begin
    exec_o.sum          = sum;
    exec_o.shift_result = shift_result;
    exec_o.logic_result = logic_result;
    exec_o.operand_a    = decode_i.operand_a;
    // abs picks between a and -a, the latter comes from the adder
    exec_o.minmax_b     = decode_i.is_abs ? sum : decode_i.operand_b;
    exec_o.is_equal     = is_equal;
    exec_o.is_greater   = is_greater;
    exec_o.do_min       = decode_i.do_min;
    exec_o.cmp_mode     = decode_i.cmp_mode;
    exec_o.res_sel      = decode_i.res_sel;
  end

endmodule

`default_nettype wire

//--- verilog/alu_pipe_reg.sv
// One-entry valid/ready pipeline register, payload type set by parameter.
// Sits between ALU stages, ready flows back combinationally.
`timescale 1ns/1ps
`default_nettype none

module alu_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n_i,

  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,

  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  // free slot, or the held item leaves this cycle
  assign ready_o = ~valid_q | ready_i;

  // valid follows the input whenever the slot can take a new item
  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
      valid_q <= 1'b0;
    else if (ready_o)
      valid_q <= valid_i;
  end

  // payload only moves on an input transfer
  always_ff @(posedge clk)
  begin
    if (valid_i && ready_o)
      data_q <= data_i;
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

`default_nettype wire

//--- verilog/alu_pkg.sv
// Shared widths, operator encoding and stage payload types for the pipelined ALU.
// Every ALU module and the testbench take these by a wildcard import.
`default_nettype none

package alu_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  localparam int DATA_WIDTH   = 32;
  localparam int BYTE_WIDTH   = 8;
  localparam int NUM_BYTES    = DATA_WIDTH / BYTE_WIDTH;
  // only the low bits of operand b are a shift amount
  localparam int SHAMT_WIDTH  = 5;
  localparam int ALU_OP_WIDTH = 5;

  ////////////////////////////////////////
  // encodings
  ////////////////////////////////////////

  typedef enum logic [ALU_OP_WIDTH-1:0] {
    ALU_ADD, ALU_SUB,
    ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_ROR,
    ALU_EQ, ALU_NE,
    ALU_GTS, ALU_GTU, ALU_GES, ALU_GEU,
    ALU_LTS, ALU_LTU, ALU_LES, ALU_LEU,
    ALU_SLTS, ALU_SLTU, ALU_SLETS, ALU_SLETU,
    ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU, ALU_ABS
  } alu_op_e;

  // relation reported as the comparison bit
  typedef enum logic [2:0] {CMP_EQ, CMP_NE, CMP_GT, CMP_GE, CMP_LT, CMP_LE} cmp_mode_e;

  // unit that drives the result word
  // cmp_word replicates the flag, cmp_bit puts it in bit 0
  typedef enum logic [2:0] {
    RES_ADD, RES_LOGIC, RES_SHIFT, RES_CMP_WORD, RES_CMP_BIT, RES_MINMAX
  } res_sel_e;

  typedef enum logic [1:0] {LOGIC_AND, LOGIC_OR, LOGIC_XOR} logic_op_e;

  ////////////////////////////////////////
  // stage payloads
  ////////////////////////////////////////

  // decode -> execute
  typedef struct packed {
    logic [DATA_WIDTH-1:0] adder_a;    // a, or ~a for abs
    logic [DATA_WIDTH-1:0] adder_b;    // b, ~b for sub, zero for abs
    logic [DATA_WIDTH-1:0] operand_a;  // compare and min/max side a
    logic [DATA_WIDTH-1:0] operand_b;  // logic, shift and compare side b
    logic                  carry_in;
    logic                  shift_left;
    logic                  arithmetic;
    logic                  rotate;
    logic                  cmp_signed;
    logic                  do_min;
    logic                  is_abs;
    cmp_mode_e             cmp_mode;
    res_sel_e              res_sel;
    logic_op_e             logic_op;
  } decode_pld_t;

  // execute -> result
  typedef struct packed {
    logic [DATA_WIDTH-1:0] sum;
    logic [DATA_WIDTH-1:0] shift_result;
    logic [DATA_WIDTH-1:0] logic_result;
    logic [DATA_WIDTH-1:0] operand_a;
    logic [DATA_WIDTH-1:0] minmax_b;
    logic                  is_equal;
    logic                  is_greater;
    logic                  do_min;
    cmp_mode_e             cmp_mode;
    res_sel_e              res_sel;
  } exec_pld_t;

  // result -> outputs
  typedef struct packed {
    logic [DATA_WIDTH-1:0] result;
    logic                  cmp_bit;
  } result_pld_t;

endpackage

`default_nettype wire

//--- verilog/alu_result_stage.sv
// Result stage, forms the comparison bit, the min/max value and the output word.
`timescale 1ns/1ps
`default_nettype none

module alu_result_stage import alu_pkg::*; (
  input  exec_pld_t   exec_i,
  output result_pld_t result_o
);

  logic                  cmp_bit;
  logic                  sel_a;
  logic [DATA_WIDTH-1:0] minmax_result;

  ////////////////////////////////////////
  // comparison outcome
  ////////////////////////////////////////

  always_comb
  begin
    unique case (exec_i.cmp_mode)
      CMP_NE:  cmp_bit = ~exec_i.is_equal;
      CMP_GT:  cmp_bit = exec_i.is_greater;
      CMP_GE:  cmp_bit = exec_i.is_greater | exec_i.is_equal;
      CMP_LT:  cmp_bit = ~(exec_i.is_greater | exec_i.is_equal);
      CMP_LE:  cmp_bit = ~exec_i.is_greater;
      default: cmp_bit = exec_i.is_equal;
    endcase
  end

  ////////////////////////////////////////
  // min / max / abs
  ////////////////////////////////////////

  // max keeps a when greater, min inverts the choice
  assign sel_a         = exec_i.is_greater ^ exec_i.do_min;
  assign minmax_result = sel_a ? exec_i.operand_a : exec_i.minmax_b;

  ////////////////////////////////////////
  // result mux
  ////////////////////////////////////////

  always_comb
  begin
    unique case (exec_i.res_sel)
      RES_LOGIC:    result_o.result = exec_i.logic_result;
      RES_SHIFT:    result_o.result = exec_i.shift_result;
      RES_CMP_WORD: result_o.result = {DATA_WIDTH{cmp_bit}};
      RES_CMP_BIT:  result_o.result = {{(DATA_WIDTH-1){1'b0}}, cmp_bit};
      RES_MINMAX:   result_o.result = minmax_result;
      default:      result_o.result = exec_i.sum;
    endcase
  end

  assign result_o.cmp_bit = cmp_bit;

endmodule

`default_nettype wire

//--- verilog/alu_shifter.sv
// Shared shifter, one right shift covers sll, srl, sra and ror.
// Left shifts go through bit reversal on input and output.
`timescale 1ns/1ps
`default_nettype none

module alu_shifter import alu_pkg::*; (
  input  logic [DATA_WIDTH-1:0]  operand_i,
  input  logic [SHAMT_WIDTH-1:0] shamt_i,
  input  logic                   shift_left_i,
  input  logic                   arithmetic_i,
  input  logic                   rotate_i,
  output logic [DATA_WIDTH-1:0]  result_o
);

  logic [DATA_WIDTH-1:0]   operand_rev;
  logic [DATA_WIDTH-1:0]   shift_in;
  logic [DATA_WIDTH-1:0]   upper_half;
  logic [2*DATA_WIDTH-1:0] shift_wide;
  logic [DATA_WIDTH-1:0]   right_result;
  logic [DATA_WIDTH-1:0]   right_rev;

  // bit reversal of the operand and of the shifted word
  always_comb
  begin
    for (int k = 0; k < DATA_WIDTH; k++)
    begin
      operand_rev[k] = operand_i[DATA_WIDTH-1-k];
      right_rev[k]   = right_result[DATA_WIDTH-1-k];
    end
  end

  assign shift_in = shift_left_i ? operand_rev : operand_i;

  // upper half feeds the bits shifted in from the top
  // copy of operand wraps around for rotate, else sign or zero fill
  assign upper_half = rotate_i ? shift_in :
                      {DATA_WIDTH{arithmetic_i & shift_in[DATA_WIDTH-1]}};

  assign shift_wide   = {upper_half, shift_in} >> shamt_i;
  assign right_result = shift_wide[DATA_WIDTH-1:0];

  assign result_o = shift_left_i ? right_rev : right_result;

endmodule

`default_nettype wire

//--- verilog/alu_top.sv
// Three-stage pipelined ALU top, decode, execute and result each behind a register.
// Valid/ready toward the producer and the consumer, three cycles in flight.
`timescale 1ns/1ps
`default_nettype none

module alu_top import alu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n_i,

  // producer side
  input  logic                  valid_i,
  output logic                  ready_o,
  input  alu_op_e               operator_i,
  input  logic [DATA_WIDTH-1:0] operand_a_i,
  input  logic [DATA_WIDTH-1:0] operand_b_i,

  // consumer side
  output logic                  valid_o,
  input  logic                  ex_ready_i,
  output logic [DATA_WIDTH-1:0] result_o,
  output logic                  comparison_result_o
);

  decode_pld_t decode_d;
  decode_pld_t decode_q;
  exec_pld_t   exec_d;
  exec_pld_t   exec_q;
  result_pld_t result_d;
  result_pld_t result_q;

  // handshakes between registers
  logic decode_valid;
  logic decode_ready;
  logic exec_valid;
  logic exec_ready;

  ////////////////////////////////////////
  // stage 1: decode
  ////////////////////////////////////////

  alu_decode_stage i_alu_decode_stage (
    .operator_i  (operator_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .decode_o    (decode_d)
  );

  alu_pipe_reg #(.payload_t(decode_pld_t)) i_decode_reg (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .data_i  (decode_d),
    .valid_o (decode_valid),
    .ready_i (decode_ready),
    .data_o  (decode_q)
  );

  ////////////////////////////////////////
  // stage 2: execute
  ////////////////////////////////////////

  alu_execute_stage i_alu_execute_stage (
    .decode_i (decode_q),
    .exec_o   (exec_d)
  );

  alu_pipe_reg #(.payload_t(exec_pld_t)) i_exec_reg (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .valid_i (decode_valid),
    .ready_o (decode_ready),
    .data_i  (exec_d),
    .valid_o (exec_valid),
    .ready_i (exec_ready),
    .data_o  (exec_q)
  );

  ////////////////////////////////////////
  // stage 3: result
  ////////////////////////////////////////

  alu_result_stage i_alu_result_stage (
    .exec_i   (exec_q),
    .result_o (result_d)
  );

  // output register holds while the consumer stalls
  alu_pipe_reg #(.payload_t(result_pld_t)) i_result_reg (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .valid_i (exec_valid),
    .ready_o (exec_ready),
    .data_i  (result_d),
    .valid_o (valid_o),
    .ready_i (ex_ready_i),
    .data_o  (result_q)
  );

  assign result_o            = result_q.result;
  assign comparison_result_o = result_q.cmp_bit;

endmodule

`default_nettype wire
